/* src.f */
exec_pkg.sv
lane_req_if.sv
issue_ctrl.sv
alu_lane.sv
mul_lane.sv
writeback_regfile.sv
exec_core.sv
exec_core_chk.sv
tb_exec_core.sv

/* Bender.yml */
package:
  name: exec_core

sources:
  - exec_pkg.sv
  - lane_req_if.sv
  - issue_ctrl.sv
  - alu_lane.sv
  - mul_lane.sv
  - writeback_regfile.sv
  - exec_core.sv
  - target: test
    files:
      - exec_core_chk.sv
      - tb_exec_core.sv

/* tb_exec_core.sv */
`timescale 1ns/100ps

module tb_exec_core;
   import exec_pkg::*;

   // Rough length of each test in cycles, two cycles per APB transfer
   localparam int RESET_LEN   = 80;
   localparam int REGWIN_LEN  = 130;
   localparam int ALU_LEN     = 160;
   localparam int MUL_LEN     = 130;
   localparam int CHAIN_LEN   = 130;
   localparam int ERROR_LEN   = 70;
   localparam int CYCLE_LIMIT =
      (RESET_LEN + REGWIN_LEN + ALU_LEN + MUL_LEN + CHAIN_LEN + ERROR_LEN) * 8;

   logic                  clk;
   logic                  rst_n;
   logic                  psel, penable, pwrite;
   logic [APB_ADDR_W-1:0] paddr;
   logic [DATA_W-1:0]     pwdata;
   logic [DATA_W-1:0]     prdata;
   logic                  pready, pslverr;

   logic [DATA_W-1:0] model [REG_N];
   string             name_q [$];
   logic [DATA_W-1:0] exp_q [$];
   logic [DATA_W-1:0] got_q [$];
   int                seed = 27753;
   int                cycles = 0;
   // Integer opcodes first, then the two multiplies
   opcode_e           all_opc [8] = '{OPC_ADD, OPC_SUB, OPC_AND, OPC_OR,
                                      OPC_XOR, OPC_SLT, OPC_MUL, OPC_MULHU};

   exec_core dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel_i    (psel),
      .penable_i (penable),
      .pwrite_i  (pwrite),
      .paddr_i   (paddr),
      .pwdata_i  (pwdata),
      .prdata_o  (prdata),
      .pready_o  (pready),
      .pslverr_o (pslverr)
   );

   always #10 clk = ~clk;

   ////////////////////
   // Reference model
   ////////////////////
   function automatic logic [DATA_W-1:0] ref_exec(input logic [OPC_W-1:0]     opc,
                                                  input logic [REG_IDX_W-1:0] rs,
                                                  input logic [REG_IDX_W-1:0] rt);
      logic [DATA_W-1:0]   a;
      logic [DATA_W-1:0]   b;
      logic [2*DATA_W-1:0] prod;
      a    = model[rs];
      b    = model[rt];
      prod = {{DATA_W{1'b0}}, a} * {{DATA_W{1'b0}}, b};
      case (opc)
         OPC_ADD:   return a + b;
         OPC_SUB:   return a - b;
         OPC_AND:   return a & b;
         OPC_OR:    return a | b;
         OPC_XOR:   return a ^ b;
         OPC_SLT:   return ($signed(a) < $signed(b)) ? 1 : 0;
         OPC_MUL:   return prod[DATA_W-1:0];
         OPC_MULHU: return prod[2*DATA_W-1:DATA_W];
         default:   return '0;
      endcase
   endfunction

   function automatic logic [REG_IDX_W-1:0] rand_reg();
      return REG_IDX_W'($unsigned($random(seed)));
   endfunction

   ////////////////////
   // APB master tasks
   ////////////////////
   // Called on a falling edge, returns on a falling edge with the bus idle
   task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      while (!pready) @(posedge clk);
      err = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      while (!pready) @(posedge clk);
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic queue_check(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] got);
      name_q.push_back(name);
      exp_q.push_back(exp);
      got_q.push_back(got);
   endtask

   task automatic issue_instr(input string name, input logic [OPC_W-1:0] opc,
                              input logic [REG_IDX_W-1:0] rd, input logic [REG_IDX_W-1:0] rs,
                              input logic [REG_IDX_W-1:0] rt);
      logic              err;
      logic [DATA_W-1:0] result;
      result = ref_exec(opc, rs, rt);
      apb_write(ISSUE_ADDR, {opc, rd, rs, rt, 11'b0}, err);
      queue_check({name, " issue pslverr"}, 0, err);
      model[rd] = result;
   endtask

   task automatic check_regs(input string name);
      logic [DATA_W-1:0] rdata;
      logic              err;
      for (int i = 0; i < REG_N; i++) begin
         apb_read(REG_BASE_ADDR + APB_ADDR_W'(i * 4), rdata, err);
         queue_check($sformatf("%s r%0d", name, i), model[i], rdata);
         queue_check($sformatf("%s r%0d pslverr", name, i), 0, err);
      end
   endtask

   task automatic wait_idle();
      logic [DATA_W-1:0] status;
      logic              err;
      status = 1;
      while (status[0]) apb_read(STATUS_ADDR, status, err);
   endtask

   ////////////////////
   // Comparison and timeout
   ////////////////////
   always @(negedge clk) begin : compare
      while (name_q.size() > 0) begin
         assert (got_q[0] === exp_q[0]) else begin
            $display("ERROR %s: expected %h, actual %h", name_q[0], exp_q[0], got_q[0]);
            $display("Simulation failed");
            $fatal(1, "Mismatch in %s", name_q[0]);
         end
         exp_q.pop_front();
         got_q.pop_front();
         name_q.pop_front();
      end
   end

   always @(posedge clk) begin : watchdog
      cycles++;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $fatal(1, "Timeout");
      end
   end

   ////////////////////
   // Tests
   ////////////////////
   initial begin : stimulus
      logic                 err;
      logic [DATA_W-1:0]    rdata;
      logic [DATA_W-1:0]    wval;
      logic [REG_IDX_W-1:0] prev_rd;
      logic [REG_IDX_W-1:0] rd;
      clk     = 1'b0;
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      for (int i = 0; i < REG_N; i++) begin
         model[i] = '0;
      end
      repeat (10) @(negedge clk);
      rst_n = 1'b1;

      // Reset state
      check_regs("reset");
      apb_read(STATUS_ADDR, rdata, err);
      queue_check("reset status", 0, rdata);
      queue_check("reset status pslverr", 0, err);

      // Register window
      for (int i = 0; i < REG_N; i++) begin
         wval = $random(seed);
         apb_write(REG_BASE_ADDR + APB_ADDR_W'(i * 4), wval, err);
         queue_check("regwin write pslverr", 0, err);
         model[i] = wval;
      end
      check_regs("regwin");

      // Integer lane
      for (int n = 0; n < 30; n++) begin
         issue_instr("alu", all_opc[$unsigned($random(seed)) % 6], rand_reg(), rand_reg(),
                     rand_reg());
      end
      wait_idle();
      check_regs("alu");

      // Multiplies back to back, then integer ops right behind a multiply
      for (int n = 0; n < 8; n++) begin
         issue_instr("mul", all_opc[6 + n % 2], rand_reg(), rand_reg(), rand_reg());
      end
      for (int n = 0; n < 6; n++) begin
         issue_instr("mul pair", all_opc[6 + n % 2], rand_reg(), rand_reg(), rand_reg());
         issue_instr("alu pair", all_opc[$unsigned($random(seed)) % 6], rand_reg(),
                     rand_reg(), rand_reg());
      end
      wait_idle();
      check_regs("mul");

      // Dependency chain over both lanes
      prev_rd = rand_reg();
      for (int n = 0; n < 12; n++) begin
         rd = rand_reg();
         issue_instr("chain", all_opc[$unsigned($random(seed)) % 8], rd, prev_rd, rand_reg());
         prev_rd = rd;
      end
      wait_idle();
      check_regs("chain");

      // Error responses
      apb_write(ISSUE_ADDR, {6'h3F, 26'h0}, err);
      queue_check("illegal opcode pslverr", 1, err);
      apb_write(12'h800, $random(seed), err);
      queue_check("unmapped write pslverr", 1, err);
      apb_read(12'h0FC, rdata, err);
      queue_check("unmapped read pslverr", 1, err);
      check_regs("errors");

      wait (name_q.size() == 0);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* exec_core_chk.sv */
`timescale 1ns/100ps

module exec_core_chk (
   input logic clk,
   input logic rst_n,
   input logic alu_valid_i,
   input logic mul_valid_i,
   input logic retire_valid_i,
   input logic pready_i,
   input logic pslverr_i
);

   // Scoreboard keeps the two lanes apart at writeback
   wb_no_collision: assert property (@(posedge clk) disable iff (!rst_n)
      !(alu_valid_i && mul_valid_i))
      else $error("Both lanes wrote back in the same cycle");

   err_with_ready: assert property (@(posedge clk) disable iff (!rst_n)
      pslverr_i |-> pready_i)
      else $error("pslverr_o high while pready_o is low");

   no_retire_in_reset: assert property (@(posedge clk) !rst_n |-> !retire_valid_i)
      else $error("Retire valid while reset is asserted");

endmodule

// Lane results seen on the writeback_regfile inputs inside the top level
bind exec_core exec_core_chk u_chk (
   .clk            (clk),
   .rst_n          (rst_n),
   .alu_valid_i    (alu_wb.valid),
   .mul_valid_i    (mul_wb.valid),
   .retire_valid_i (retire.valid),
   .pready_i       (pready_o),
   .pslverr_i      (pslverr_o)
);

/* exec_core.sv */
`timescale 1ns/100ps

module exec_core (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [exec_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [exec_pkg::DATA_W-1:0]     pwdata_i,
   output logic [exec_pkg::DATA_W-1:0]     prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o
);
   import exec_pkg::*;

   logic [REG_IDX_W-1:0] rs_idx, rt_idx, reg_widx;
   logic [DATA_W-1:0]    rs_data, rt_data, reg_wdata;
   logic                 reg_we;
   wb_t                  alu_wb, mul_wb, retire;

   // One request channel per lane
   lane_req_if #(.op_t(alu_op_e)) alu_req ();
   lane_req_if #(.op_t(mul_op_e)) mul_req ();

   issue_ctrl u_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .psel_i      (psel_i),
      .penable_i   (penable_i),
      .pwrite_i    (pwrite_i),
      .paddr_i     (paddr_i),
      .pwdata_i    (pwdata_i),
      .prdata_o    (prdata_o),
      .pready_o    (pready_o),
      .pslverr_o   (pslverr_o),
      .alu_req     (alu_req),
      .mul_req     (mul_req),
      .rs_idx_o    (rs_idx),
      .rt_idx_o    (rt_idx),
      .rs_data_i   (rs_data),
      .rt_data_i   (rt_data),
      .retire_i    (retire),
      .reg_we_o    (reg_we),
      .reg_widx_o  (reg_widx),
      .reg_wdata_o (reg_wdata)
   );

   alu_lane u_alu (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (alu_req),
      .wb_o  (alu_wb)
   );

   mul_lane u_mul (
      .clk   (clk),
      .rst_n (rst_n),
      .req   (mul_req),
      .wb_o  (mul_wb)
   );

   writeback_regfile u_wb (
      .clk         (clk),
      .rst_n       (rst_n),
      .alu_wb_i    (alu_wb),
      .mul_wb_i    (mul_wb),
      .reg_we_i    (reg_we),
      .reg_widx_i  (reg_widx),
      .reg_wdata_i (reg_wdata),
      .rs_idx_i    (rs_idx),
      .rt_idx_i    (rt_idx),
      .rs_data_o   (rs_data),
      .rt_data_o   (rt_data),
      .retire_o    (retire)
   );

endmodule

/* writeback_regfile.sv */
`timescale 1ns/100ps

module writeback_regfile (
   input  logic                           clk,
   input  logic                           rst_n,
   input  exec_pkg::wb_t                  alu_wb_i,
   input  exec_pkg::wb_t                  mul_wb_i,
   input  logic                           reg_we_i,
   input  logic [exec_pkg::REG_IDX_W-1:0] reg_widx_i,
   input  logic [exec_pkg::DATA_W-1:0]    reg_wdata_i,
   input  logic [exec_pkg::REG_IDX_W-1:0] rs_idx_i,
   input  logic [exec_pkg::REG_IDX_W-1:0] rt_idx_i,
   output logic [exec_pkg::DATA_W-1:0]    rs_data_o,
   output logic [exec_pkg::DATA_W-1:0]    rt_data_o,
   output exec_pkg::wb_t                  retire_o
);
   import exec_pkg::*;

   logic [DATA_W-1:0] regs [REG_N];
   wb_t               retire;

   ////////////////////
   // Result merge
   ////////////////////
   // The two lanes never retire in the same cycle
   assign retire   = alu_wb_i.valid ? alu_wb_i : mul_wb_i;
   assign retire_o = retire;

   ////////////////////
   // Register file
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < REG_N; i++) begin
            regs[i] <= '0;
         end
      end else if (retire.valid) begin
         regs[retire.rd] <= retire.data;
      end else if (reg_we_i) begin
         // APB writes only pass when nothing is pending
         regs[reg_widx_i] <= reg_wdata_i;
      end
   end

   // Asynchronous read ports
   assign rs_data_o = regs[rs_idx_i];
   assign rt_data_o = regs[rt_idx_i];

endmodule

/* mul_lane.sv */
`timescale 1ns/100ps

module mul_lane (
   input  logic          clk,
   input  logic          rst_n,
   lane_req_if.lane      req,
   output exec_pkg::wb_t wb_o
);
   import exec_pkg::*;

   // Valid bit per stage
   logic [2:0]             valid_q;
   logic [REG_IDX_W-1:0]   rd_q1, rd_q2, rd_q3;
   mul_op_e                op_q1, op_q2;
   logic [DATA_W-1:0]      pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
   logic [2*DATA_W-1:0]    prod_q;
   logic [DATA_W-1:0]      data_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else begin
         valid_q <= {valid_q[1:0], req.valid};
      end
   end

   always_ff @(posedge clk) begin
      // Stage 1 partial products of the 16-bit halves
      pp_ll_q <= req.opa[DATA_W/2-1:0] * req.opb[DATA_W/2-1:0];
      pp_lh_q <= req.opa[DATA_W/2-1:0] * req.opb[DATA_W-1:DATA_W/2];
      pp_hl_q <= req.opa[DATA_W-1:DATA_W/2] * req.opb[DATA_W/2-1:0];
      pp_hh_q <= req.opa[DATA_W-1:DATA_W/2] * req.opb[DATA_W-1:DATA_W/2];
      rd_q1   <= req.rd;
      op_q1   <= req.op;

      // Stage 2 full 64-bit product
      prod_q <= {pp_hh_q, pp_ll_q}
              + ({{DATA_W{1'b0}}, pp_lh_q} << (DATA_W/2))
              + ({{DATA_W{1'b0}}, pp_hl_q} << (DATA_W/2));
      rd_q2  <= rd_q1;
      op_q2  <= op_q1;

      // Stage 3 picks the half
      data_q <= (op_q2 == MUL_HI) ? prod_q[2*DATA_W-1:DATA_W] : prod_q[DATA_W-1:0];
      rd_q3  <= rd_q2;
   end

   assign wb_o.valid = valid_q[2];
   assign wb_o.rd    = rd_q3;
   assign wb_o.data  = data_q;

endmodule

/* alu_lane.sv */
`timescale 1ns/100ps

module alu_lane (
   input  logic          clk,
   input  logic          rst_n,
   lane_req_if.lane      req,
   output exec_pkg::wb_t wb_o
);
   import exec_pkg::*;

   logic [DATA_W-1:0]    result;
   logic                 valid_q;
   logic [REG_IDX_W-1:0] rd_q;
   logic [DATA_W-1:0]    data_q;

   always_comb begin
      case (req.op)
         ALU_ADD: result = req.opa + req.opb;
         ALU_SUB: result = req.opa - req.opb;
         ALU_AND: result = req.opa & req.opb;
         ALU_OR:  result = req.opa | req.opb;
         ALU_XOR: result = req.opa ^ req.opb;
         // Signed compare giving 0 or 1
         ALU_SLT: result = {{(DATA_W-1){1'b0}}, $signed(req.opa) < $signed(req.opb)};
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= req.valid;
      end
   end

   always_ff @(posedge clk) begin
      rd_q   <= req.rd;
      data_q <= result;
   end

   assign wb_o.valid = valid_q;
   assign wb_o.rd    = rd_q;
   assign wb_o.data  = data_q;

endmodule

/* issue_ctrl.sv */
`timescale 1ns/100ps

module issue_ctrl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [exec_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [exec_pkg::DATA_W-1:0]     pwdata_i,
   output logic [exec_pkg::DATA_W-1:0]     prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   lane_req_if.issue                       alu_req,
   lane_req_if.issue                       mul_req,
   output logic [exec_pkg::REG_IDX_W-1:0]  rs_idx_o,
   output logic [exec_pkg::REG_IDX_W-1:0]  rt_idx_o,
   input  logic [exec_pkg::DATA_W-1:0]     rs_data_i,
   input  logic [exec_pkg::DATA_W-1:0]     rt_data_i,
   input  exec_pkg::wb_t                   retire_i,
   output logic                            reg_we_o,
   output logic [exec_pkg::REG_IDX_W-1:0]  reg_widx_o,
   output logic [exec_pkg::DATA_W-1:0]     reg_wdata_o
);
   import exec_pkg::*;

   logic [REG_N-1:0]     pending;
   logic [1:0]           mul_hist;
   logic                 access, xfer;
   logic                 issue_hit, status_hit, reg_hit;
   logic [REG_IDX_W-1:0] reg_idx;
   logic [OPC_W-1:0]     ins_opc;
   logic [REG_IDX_W-1:0] ins_rd, ins_rs, ins_rt;
   logic                 opc_legal, is_mul, hazard, issue_fire;
   alu_op_e              alu_op;
   mul_op_e              mul_op;

   ////////////////////
   // Address and instruction decode
   ////////////////////
   assign access     = psel_i & penable_i;
   assign issue_hit  = (paddr_i == ISSUE_ADDR);
   assign status_hit = (paddr_i == STATUS_ADDR);
   assign reg_hit    = (paddr_i[APB_ADDR_W-1:REG_IDX_W+2] ==
                        REG_BASE_ADDR[APB_ADDR_W-1:REG_IDX_W+2]) &&
                       (paddr_i[1:0] == 2'b00);
   assign reg_idx    = paddr_i[REG_IDX_W+1:2];

   assign ins_opc = pwdata_i[31:26];
   assign ins_rd  = pwdata_i[25:21];
   assign ins_rs  = pwdata_i[20:16];
   assign ins_rt  = pwdata_i[15:11];

   always_comb begin
      opc_legal = 1'b1;
      is_mul    = 1'b0;
      alu_op    = ALU_ADD;
      mul_op    = MUL_LO;
      case (ins_opc)
         OPC_ADD: alu_op = ALU_ADD;
         OPC_SUB: alu_op = ALU_SUB;
         OPC_AND: alu_op = ALU_AND;
         OPC_OR:  alu_op = ALU_OR;
         OPC_XOR: alu_op = ALU_XOR;
         OPC_SLT: alu_op = ALU_SLT;
         OPC_MUL: is_mul = 1'b1;
         OPC_MULHU: begin
            is_mul = 1'b1;
            mul_op = MUL_HI;
         end
         default: opc_legal = 1'b0;
      endcase
   end

   // Integer result would land on the same writeback cycle as a multiply
   // accepted two cycles ago
   assign hazard = pending[ins_rs] | pending[ins_rt] | pending[ins_rd] |
                   (~is_mul & mul_hist[1]);

   ////////////////////
   // APB response
   ////////////////////
   always_comb begin
      pready_o  = 1'b0;
      pslverr_o = 1'b0;
      prdata_o  = '0;
      if (access) begin
         pready_o = 1'b1;
         if (issue_hit && pwrite_i && opc_legal) begin
            pready_o = ~hazard;
         end else if (reg_hit && pwrite_i) begin
            pready_o = ~(|pending);
         end else if (reg_hit) begin
            pready_o = ~pending[reg_idx];
            prdata_o = rs_data_i;
         end else if (status_hit && !pwrite_i) begin
            prdata_o = {{(DATA_W-1){1'b0}}, |pending};
         end else begin
            // Illegal opcode, wrong direction or unmapped address
            pslverr_o = 1'b1;
         end
      end
   end

   assign xfer       = access & pready_o;
   assign issue_fire = xfer & issue_hit & pwrite_i & opc_legal;

   ////////////////////
   // Register file access and lane issue
   ////////////////////
   assign rs_idx_o    = issue_hit ? ins_rs : reg_idx;
   assign rt_idx_o    = ins_rt;
   assign reg_we_o    = xfer & reg_hit & pwrite_i;
   assign reg_widx_o  = reg_idx;
   assign reg_wdata_o = pwdata_i;

   assign alu_req.valid = issue_fire & ~is_mul;
   assign alu_req.op    = alu_op;
   assign alu_req.opa   = rs_data_i;
   assign alu_req.opb   = rt_data_i;
   assign alu_req.rd    = ins_rd;

   assign mul_req.valid = issue_fire & is_mul;
   assign mul_req.op    = mul_op;
   assign mul_req.opa   = rs_data_i;
   assign mul_req.opb   = rt_data_i;
   assign mul_req.rd    = ins_rd;

   ////////////////////
   // Scoreboard
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending  <= '0;
         mul_hist <= '0;
      end else begin
         // A retiring rd is never re-issued in the same cycle
         pending <= (pending & ~({{(REG_N-1){1'b0}}, retire_i.valid} << retire_i.rd)) |
                    ({{(REG_N-1){1'b0}}, issue_fire} << ins_rd);
         mul_hist <= {mul_hist[0], mul_req.valid};
      end
   end

endmodule

/* lane_req_if.sv */
`timescale 1ns/100ps

interface lane_req_if #(
   parameter type op_t = logic
) ();
   import exec_pkg::*;

   logic                 valid;
   op_t                  op;
   logic [DATA_W-1:0]    opa;
   logic [DATA_W-1:0]    opb;
   logic [REG_IDX_W-1:0] rd;

   // Issue side drives, the lane only listens
   modport issue (
      output valid, op, opa, opb, rd
   );

   modport lane (
      input valid, op, opa, opb, rd
   );

endinterface

/* exec_pkg.sv */
package exec_pkg;

   ////////////////////
   // Widths
   ////////////////////
   localparam int DATA_W     = 32;
   localparam int REG_N      = 32;
   localparam int REG_IDX_W  = 5;
   localparam int OPC_W      = 6;
   localparam int APB_ADDR_W = 12;

   ////////////////////
   // APB address map
   ////////////////////
   // Byte addresses, one 32-bit word per location
   localparam logic [APB_ADDR_W-1:0] ISSUE_ADDR    = 12'h000;
   localparam logic [APB_ADDR_W-1:0] STATUS_ADDR   = 12'h004;
   // Register window spans 32 words from here
   localparam logic [APB_ADDR_W-1:0] REG_BASE_ADDR = 12'h100;

   ////////////////////
   // Encodings
   ////////////////////
   typedef enum logic [OPC_W-1:0] {
      OPC_ADD   = 6'h01,
      OPC_SUB   = 6'h02,
      OPC_AND   = 6'h03,
      OPC_OR    = 6'h04,
      OPC_XOR   = 6'h05,
      OPC_SLT   = 6'h06,
      OPC_MUL   = 6'h08,
      OPC_MULHU = 6'h09
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT
   } alu_op_e;

   // Low or high half of the 64-bit product
   typedef enum logic {
      MUL_LO,
      MUL_HI
   } mul_op_e;

   typedef struct packed {
      logic                 valid;
      logic [REG_IDX_W-1:0] rd;
      logic [DATA_W-1:0]    data;
   } wb_t;

endpackage
